/* sync_uart.f */
+incdir+dv
logic/sync_uart_pkg.sv
logic/byte_fifo.sv
logic/uart_tx.sv
logic/uart_rx.sv
logic/uart_regs.sv
logic/sync_uart.sv
dv/sync_uart_tb.sv

/* Bender.yml */
package:
  name: sync_uart

sources:
  - logic/sync_uart_pkg.sv
  - logic/byte_fifo.sv
  - logic/uart_tx.sv
  - logic/uart_rx.sv
  - logic/uart_regs.sv
  - logic/sync_uart.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/sync_uart_tb.sv

/* dv/sync_uart_tests.svh */
// Directed tests for the system-clock UART
// Reset state and unmapped read
// Transmit and receive ordering, both FIFOs filled
// Transmit and receive interrupts

`ifndef SYNC_UART_TESTS_SVH
`define SYNC_UART_TESTS_SVH

// Idle line, no interrupt, empty FIFOs, CTS not yet active
task check_reset_state();
    @(negedge i_clk);
    assert (o_uart_txd === 1'b1 && o_uart_int === 1'b0)
    else
        stop_on_error($sformatf("Fail at %0t: txd %b int %b after reset",
                                $time, o_uart_txd, o_uart_int));
    check_reg(UART_FR, expected_fr(1'b1, 1'b0, 1'b0, 1'b1, 1'b0), "FR");
    check_reg(16'h0004, 32'h00c0ffee, "unmapped offset");
endtask

// Held by CTS, then released
task transmit_in_order();
    byte_t  sent [0:3];
    byte_t  got;
    integer i;
    for (i = 0; i < 4; i++)
    begin
        sent[i] = next_byte();
        bus_write(UART_DR, {24'd0, sent[i]});
    end
    expect_idle_line(3);
    @(posedge i_clk);
    i_uart_cts_n <= 1'b0;
    for (i = 0; i < 4; i++)
    begin
        recv_serial(got);
        assert (got === sent[i])
        else
            stop_on_error($sformatf("Fail at %0t: frame %0d carried 0x%02h, expected 0x%02h",
                                    $time, i, got, sent[i]));
    end
    wait_tx_drained();
endtask

task receive_in_order();
    byte_t  sent [0:4];
    integer i;
    for (i = 0; i < 5; i++)
    begin
        sent[i] = next_byte();
        send_serial(sent[i]);
    end
    for (i = 0; i < 5; i++)
        check_reg(UART_DR, {24'd0, sent[i]}, "DR");
    // CTS is active from the transmit test
    check_reg(UART_FR, expected_fr(1'b1, 1'b0, 1'b0, 1'b1, 1'b1), "FR");
endtask

// 16 bytes fill the receive FIFO and raise RTS
task fill_receive_fifo();
    byte_t  sent [0:15];
    integer i;
    for (i = 0; i < 16; i++)
    begin
        sent[i] = next_byte();
        send_serial(sent[i]);
    end
    wait_rts(1'b1);
    check_reg(UART_FR, expected_fr(1'b1, 1'b1, 1'b0, 1'b0, 1'b1), "FR");
    check_reg(UART_DR, {24'd0, sent[0]}, "DR");
    // One free entry lets the receiver restart
    wait_rts(1'b0);
    for (i = 1; i < 16; i++)
        check_reg(UART_DR, {24'd0, sent[i]}, "DR");
endtask

// 17th write is dropped and only 16 frames follow
task fill_transmit_fifo();
    byte_t  sent [0:16];
    byte_t  got;
    integer i;
    @(posedge i_clk);
    i_uart_cts_n <= 1'b1;
    for (i = 0; i < 17; i++)
    begin
        sent[i] = next_byte();
        bus_write(UART_DR, {24'd0, sent[i]});
    end
    check_reg(UART_FR, expected_fr(1'b0, 1'b0, 1'b1, 1'b1, 1'b0), "FR");
    @(posedge i_clk);
    i_uart_cts_n <= 1'b0;
    for (i = 0; i < 16; i++)
    begin
        recv_serial(got);
        assert (got === sent[i])
        else
            stop_on_error($sformatf("Fail at %0t: frame %0d carried 0x%02h, expected 0x%02h",
                                    $time, i, got, sent[i]));
    end
    // A 17th frame would start inside this window
    expect_idle_line(3);
    wait_tx_drained();
endtask

task interrupt_levels();
    byte_t  sent [0:7];
    integer i;
    // Empty transmit FIFO is below the half mark
    bus_write(UART_CR, 32'h1 << CR_TX_INT_EN);
    wait_int(1'b1);
    check_reg(UART_IIR, 32'h4, "IIR");
    // Receive interrupt alone with its threshold at 8 bytes
    bus_write(UART_CR, 32'h1 << CR_RX_INT_EN);
    wait_int(1'b0);
    for (i = 0; i < 7; i++)
    begin
        sent[i] = next_byte();
        send_serial(sent[i]);
    end
    assert (o_uart_int === 1'b0)
    else
        stop_on_error($sformatf("Fail at %0t: interrupt raised with 7 bytes held", $time));
    sent[7] = next_byte();
    send_serial(sent[7]);
    wait_int(1'b1);
    check_reg(UART_IIR, 32'h2, "IIR");
    check_reg(UART_DR, {24'd0, sent[0]}, "DR");
    wait_int(1'b0);
    for (i = 1; i < 8; i++)
        check_reg(UART_DR, {24'd0, sent[i]}, "DR");
endtask

`endif

/* dv/sync_uart_tb.sv */
// Testbench for the system-clock UART
// Clock, reset and DUT instance
// Bus read and write tasks, serial send and receive tasks
// Directed test sequence from the included test tasks

`timescale 1ns/100ps

module sync_uart_tb;
    import sync_uart_pkg::*;

    localparam int CLKS_PER_BIT = 16;
    localparam int FIFO_DEPTH   = 16;
    // Bounds for every wait loop
    localparam int ACK_LIMIT    = 8;
    localparam int POLL_LIMIT   = 64;
    localparam int FRAME_LIMIT  = 20 * CLKS_PER_BIT;

    logic       i_clk;
    logic       i_reset;
    wb_addr_t   i_wb_adr;
    logic       i_wb_we;
    wb_data_t   i_wb_dat;
    logic       i_wb_cyc;
    logic       i_wb_stb;
    logic       o_wb_ack;
    wb_data_t   o_wb_dat;
    logic       o_uart_int;
    logic       i_uart_cts_n;
    logic       o_uart_txd;
    logic       o_uart_rts_n;
    logic       i_uart_rxd;
    integer     seed = 59014;

    sync_uart #(.CLKS_PER_BIT(CLKS_PER_BIT), .FIFO_DEPTH(FIFO_DEPTH)) u_sync_uart (
        .i_clk(i_clk), .i_reset(i_reset),
        .i_wb_adr(i_wb_adr), .i_wb_we(i_wb_we), .i_wb_dat(i_wb_dat),
        .i_wb_cyc(i_wb_cyc), .i_wb_stb(i_wb_stb),
        .o_wb_ack(o_wb_ack), .o_wb_dat(o_wb_dat), .o_uart_int(o_uart_int),
        .i_uart_cts_n(i_uart_cts_n), .o_uart_txd(o_uart_txd),
        .o_uart_rts_n(o_uart_rts_n), .i_uart_rxd(i_uart_rxd)
    );

    // 4 ns clock
    initial
    begin
        i_clk = 1'b0;
        forever #2 i_clk = ~i_clk;
    end

    // ==========================================================================
    // Error stop and small helpers
    // ==========================================================================
    task stop_on_error(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    function byte_t next_byte();
        integer r;
        r = $random(seed);
        return r[7:0];
    endfunction

    // FR layout, MSB first: tx empty, rx full, tx full, rx empty, busy, 1, 1, CTS
    function wb_data_t expected_fr(input logic tx_empty, input logic rx_full,
                                   input logic tx_full, input logic rx_empty,
                                   input logic cts);
        return {24'd0, tx_empty, rx_full, tx_full, rx_empty, !tx_empty, 2'b11, cts};
    endfunction

    // ==========================================================================
    // Bus tasks, master holds the request until ack
    // ==========================================================================
    task bus_cycle(input logic write, input logic [15:0] offset,
                   input wb_data_t wdata, output wb_data_t rdata);
        integer n;
        @(posedge i_clk);
        i_wb_adr <= {16'h0000, offset};
        i_wb_we  <= write;
        i_wb_dat <= wdata;
        i_wb_cyc <= 1'b1;
        i_wb_stb <= 1'b1;
        n = 0;
        // Ack is combinational, look at it mid-cycle
        @(negedge i_clk);
        while (!o_wb_ack && n < ACK_LIMIT)
        begin
            @(negedge i_clk);
            n++;
        end
        if (!o_wb_ack)
            stop_on_error("Bus cycle was never acknowledged");
        rdata = o_wb_dat;
        // Request drops on the edge that completes the cycle
        @(posedge i_clk);
        i_wb_cyc <= 1'b0;
        i_wb_stb <= 1'b0;
        i_wb_we  <= 1'b0;
    endtask

    task bus_write(input logic [15:0] offset, input wb_data_t data);
        wb_data_t unused;
        bus_cycle(1'b1, offset, data, unused);
    endtask

    task bus_read(input logic [15:0] offset, output wb_data_t data);
        bus_cycle(1'b0, offset, 32'd0, data);
    endtask

    task check_reg(input logic [15:0] offset, input wb_data_t expected, input string what);
        wb_data_t got;
        bus_read(offset, got);
        assert (got === expected)
        else
            stop_on_error($sformatf("Fail at %0t: %s read 0x%08h, expected 0x%08h",
                                    $time, what, got, expected));
    endtask

    // ==========================================================================
    // Level waits
    // ==========================================================================
    task wait_rts(input logic level);
        integer n;
        n = 0;
        @(negedge i_clk);
        while (o_uart_rts_n !== level && n < FRAME_LIMIT)
        begin
            @(negedge i_clk);
            n++;
        end
        if (o_uart_rts_n !== level)
            stop_on_error("Request-to-send never reached the expected level");
    endtask

    task wait_int(input logic level);
        integer n;
        n = 0;
        @(negedge i_clk);
        while (o_uart_int !== level && n < POLL_LIMIT)
        begin
            @(negedge i_clk);
            n++;
        end
        if (o_uart_int !== level)
            stop_on_error("Interrupt output never reached the expected level");
    endtask

    // Poll FR until the transmit FIFO reports empty
    task wait_tx_drained();
        wb_data_t fr;
        integer n;
        n = 0;
        bus_read(UART_FR, fr);
        while (!fr[7] && n < FRAME_LIMIT)
        begin
            bus_read(UART_FR, fr);
            n++;
        end
        if (!fr[7])
            stop_on_error("Transmit FIFO never drained");
    endtask

    // ==========================================================================
    // Serial line tasks
    // ==========================================================================
    // One bit on the receive line, exactly one bit period
    task drive_bit(input logic level);
        @(posedge i_clk);
        i_uart_rxd <= level;
        repeat (CLKS_PER_BIT - 1) @(posedge i_clk);
    endtask

    // Honors RTS, then start, 8 data bits LSB first, one stop bit
    task send_serial(input byte_t data);
        integer i;
        wait_rts(1'b0);
        drive_bit(1'b0);
        for (i = 0; i < 8; i++)
            drive_bit(data[i]);
        drive_bit(1'b1);
    endtask

    // Line sampled every clock, each bit must hold for a full period
    task recv_serial(output byte_t data);
        integer n;
        integer i;
        integer k;
        logic   level;
        byte_t  value;
        n = 0;
        @(negedge i_clk);
        while (o_uart_txd && n < FRAME_LIMIT)
        begin
            @(negedge i_clk);
            n++;
        end
        if (o_uart_txd)
            stop_on_error("No start bit seen on the transmit line");
        // Bit 0 is start, 1 to 8 are data, 9 is stop
        for (i = 0; i < 10; i++)
        begin
            if (i > 0)
                @(negedge i_clk);
            level = o_uart_txd;
            for (k = 1; k < CLKS_PER_BIT; k++)
            begin
                @(negedge i_clk);
                assert (o_uart_txd === level)
                else
                    stop_on_error($sformatf("Fail at %0t: frame bit %0d not held a full period",
                                            $time, i));
            end
            if (i >= 1 && i <= 8)
                value[i-1] = level;
            if (i == 9)
                assert (level === 1'b1)
                else
                    stop_on_error($sformatf("Fail at %0t: stop bit is low", $time));
        end
        data = value;
    endtask

    // Line must stay high for the given number of bit periods
    task expect_idle_line(input integer periods);
        repeat (periods * CLKS_PER_BIT)
        begin
            @(negedge i_clk);
            assert (o_uart_txd === 1'b1)
            else
                stop_on_error($sformatf("Fail at %0t: transmit line left idle", $time));
        end
    endtask

    `include "sync_uart_tests.svh"

    // ==========================================================================
    // Test sequence
    // ==========================================================================
    initial
    begin
        i_reset      = 1'b1;
        i_wb_adr     = '0;
        i_wb_we      = 1'b0;
        i_wb_dat     = '0;
        i_wb_cyc     = 1'b0;
        i_wb_stb     = 1'b0;
        i_uart_cts_n = 1'b1;
        i_uart_rxd   = 1'b1;
        repeat (4) @(posedge i_clk);
        i_reset <= 1'b0;

        check_reset_state();
        transmit_in_order();
        receive_in_order();
        fill_receive_fifo();
        fill_transmit_fifo();
        interrupt_levels();

        $display("Test passed");
        $finish;
    end

endmodule

/* logic/sync_uart.sv */
// UART top level on the system clock
// Register block, transmit and receive FIFOs
// Transmitter and receiver

`timescale 1ns/100ps

module sync_uart
#(
    parameter int CLKS_PER_BIT = 16,
    parameter int FIFO_DEPTH   = 16
)
(
    input  logic                        i_clk,
    input  logic                        i_reset,
    input  sync_uart_pkg::wb_addr_t     i_wb_adr,
    input  logic                        i_wb_we,
    input  sync_uart_pkg::wb_data_t     i_wb_dat,
    input  logic                        i_wb_cyc,
    input  logic                        i_wb_stb,
    output logic                        o_wb_ack,
    output sync_uart_pkg::wb_data_t     o_wb_dat,
    output logic                        o_uart_int,
    input  logic                        i_uart_cts_n,
    output logic                        o_uart_txd,
    output logic                        o_uart_rts_n,
    input  logic                        i_uart_rxd
);
    import sync_uart_pkg::*;

    // Transmit path
    logic                           tx_push;
    logic                           tx_pop;
    byte_t                          tx_wr_data;
    byte_t                          tx_head;
    logic [$clog2(FIFO_DEPTH):0]    tx_count;
    logic                           tx_full;
    logic                           tx_empty;
    logic                           cts_active;
    // Receive path
    logic                           rx_push;
    logic                           rx_pop;
    byte_t                          rx_wr_data;
    byte_t                          rx_head;
    logic [$clog2(FIFO_DEPTH):0]    rx_count;
    logic                           rx_full;
    logic                           rx_empty;

    uart_regs #(.FIFO_DEPTH(FIFO_DEPTH)) u_regs (
        .i_clk(i_clk), .i_reset(i_reset),
        .i_wb_adr(i_wb_adr), .i_wb_we(i_wb_we), .i_wb_dat(i_wb_dat),
        .i_wb_cyc(i_wb_cyc), .i_wb_stb(i_wb_stb),
        .o_wb_ack(o_wb_ack), .o_wb_dat(o_wb_dat),
        .o_tx_push(tx_push), .o_tx_data(tx_wr_data),
        .i_tx_count(tx_count), .i_tx_full(tx_full), .i_tx_empty(tx_empty),
        .o_rx_pop(rx_pop), .i_rx_data(rx_head),
        .i_rx_count(rx_count), .i_rx_full(rx_full), .i_rx_empty(rx_empty),
        .i_cts_active(cts_active), .o_uart_int(o_uart_int)
    );

    // Bus writes in, transmitter drains
    byte_fifo #(.DEPTH(FIFO_DEPTH)) u_tx_fifo (
        .i_clk(i_clk), .i_reset(i_reset),
        .i_push(tx_push), .i_data(tx_wr_data), .i_pop(tx_pop), .o_data(tx_head),
        .o_count(tx_count), .o_full(tx_full), .o_empty(tx_empty)
    );

    // Receiver fills, bus reads drain
    byte_fifo #(.DEPTH(FIFO_DEPTH)) u_rx_fifo (
        .i_clk(i_clk), .i_reset(i_reset),
        .i_push(rx_push), .i_data(rx_wr_data), .i_pop(rx_pop), .o_data(rx_head),
        .o_count(rx_count), .o_full(rx_full), .o_empty(rx_empty)
    );

    uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_tx (
        .i_clk(i_clk), .i_reset(i_reset), .i_uart_cts_n(i_uart_cts_n),
        .i_fifo_empty(tx_empty), .i_fifo_data(tx_head), .o_fifo_pop(tx_pop),
        .o_cts_active(cts_active), .o_uart_txd(o_uart_txd)
    );

    uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_rx (
        .i_clk(i_clk), .i_reset(i_reset), .i_uart_rxd(i_uart_rxd),
        .i_fifo_full(rx_full), .o_fifo_push(rx_push), .o_fifo_data(rx_wr_data),
        .o_uart_rts_n(o_uart_rts_n)
    );

endmodule

/* logic/uart_regs.sv */
// UART register block
// Bus decode with same-cycle write and delayed read acknowledge
// Control register and read data mux
// FIFO strobes and registered interrupt levels

`timescale 1ns/100ps

module uart_regs
#(
    parameter int FIFO_DEPTH = 16
)
(
    input  logic                            i_clk,
    input  logic                            i_reset,
    input  sync_uart_pkg::wb_addr_t         i_wb_adr,
    input  logic                            i_wb_we,
    input  sync_uart_pkg::wb_data_t         i_wb_dat,
    input  logic                            i_wb_cyc,
    input  logic                            i_wb_stb,
    output logic                            o_wb_ack,
    output sync_uart_pkg::wb_data_t         o_wb_dat,
    output logic                            o_tx_push,
    output sync_uart_pkg::byte_t            o_tx_data,
    input  logic [$clog2(FIFO_DEPTH):0]     i_tx_count,
    input  logic                            i_tx_full,
    input  logic                            i_tx_empty,
    output logic                            o_rx_pop,
    input  sync_uart_pkg::byte_t            i_rx_data,
    input  logic [$clog2(FIFO_DEPTH):0]     i_rx_count,
    input  logic                            i_rx_full,
    input  logic                            i_rx_empty,
    input  logic                            i_cts_active,
    output logic                            o_uart_int
);
    import sync_uart_pkg::*;

    localparam int CNT_W = $clog2(FIFO_DEPTH) + 1;
    localparam logic [CNT_W-1:0] HALF_DEPTH = CNT_W'(FIFO_DEPTH / 2);

    logic [15:0]    reg_adr;
    logic           bus_req;
    logic           start_write;
    logic           start_read;
    logic           read_d1;
    logic [7:0]     cr_reg;
    logic           tx_int;
    logic           rx_int;

    // ==========================================================================
    // Bus handshake
    // ==========================================================================
    assign reg_adr     = i_wb_adr[15:0];
    assign bus_req     = i_wb_cyc && i_wb_stb;
    // Read ack must go out before a new write is taken
    assign start_write = bus_req && i_wb_we && !read_d1;
    assign start_read  = bus_req && !i_wb_we && !o_wb_ack;
    assign o_wb_ack    = bus_req && (start_write || read_d1);

    // FIFO strobes from data register accesses
    assign o_tx_push = start_write && (reg_adr == UART_DR);
    assign o_tx_data = i_wb_dat[7:0];
    assign o_rx_pop  = start_read && (reg_adr == UART_DR);

    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            read_d1 <= 1'b0;
            cr_reg  <= '0;
            tx_int  <= 1'b0;
            rx_int  <= 1'b0;
        end
        else
        begin
            read_d1 <= start_read;
            if (start_write && (reg_adr == UART_CR))
                cr_reg <= i_wb_dat[7:0];
            // IIR write knocks the tx interrupt down for a cycle
            if (start_write && (reg_adr == UART_IIR))
                tx_int <= 1'b0;
            else
                tx_int <= (i_tx_count <= HALF_DEPTH) && cr_reg[CR_TX_INT_EN];
            rx_int <= (i_rx_count >= HALF_DEPTH);
        end
    end

    assign o_uart_int = (tx_int && cr_reg[CR_TX_INT_EN]) ||
                        (rx_int && cr_reg[CR_RX_INT_EN]);

    // ==========================================================================
    // Read data, captured for the ack cycle
    // ==========================================================================
    always_ff @(posedge i_clk)
    begin
        if (start_read)
        begin
            case (reg_adr)
                UART_DR:  o_wb_dat <= {24'd0, i_rx_data};
                // Flags MSB first
                UART_FR:  o_wb_dat <= {24'd0, i_tx_empty, i_rx_full, i_tx_full, i_rx_empty,
                                       !i_tx_empty, 1'b1, 1'b1, i_cts_active};
                UART_CR:  o_wb_dat <= {24'd0, cr_reg};
                UART_IIR: o_wb_dat <= {29'd0, tx_int, rx_int, 1'b0};
                default:  o_wb_dat <= READ_DEFAULT;
            endcase
        end
    end

endmodule

/* logic/uart_rx.sv */
// UART receiver
// Five-sample start edge filter
// Restartable timer for half-bit and full-bit waits
// Receive FSM with request-to-send flow control

`timescale 1ns/100ps

module uart_rx
#(
    parameter int CLKS_PER_BIT = 16
)
(
    input  logic                    i_clk,
    input  logic                    i_reset,
    input  logic                    i_uart_rxd,
    input  logic                    i_fifo_full,
    output logic                    o_fifo_push,
    output sync_uart_pkg::byte_t    o_fifo_data,
    output logic                    o_uart_rts_n
);
    import sync_uart_pkg::*;

    localparam int CNT_W = $clog2(CLKS_PER_BIT);
    localparam logic [CNT_W-1:0] BIT_LAST  = CNT_W'(CLKS_PER_BIT - 1);
    // Detect and restart delays eat into the half bit
    localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(CLKS_PER_BIT / 2 - 3);

    logic [4:0]         rxd_d;
    logic               rx_start;
    logic [CNT_W-1:0]   bit_cnt;
    logic               cnt_restart;
    logic               half_done;
    logic               bit_done;
    logic [2:0]         bit_idx;
    rx_state_e          state;

    // ==========================================================================
    // Sample history and bit timer
    // ==========================================================================
    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            rxd_d   <= 5'h1f;
            bit_cnt <= '0;
        end
        else
        begin
            rxd_d   <= {rxd_d[3:0], i_uart_rxd};
            bit_cnt <= cnt_restart ? '0 : bit_cnt + 1'b1;
        end
    end

    // High-high then low-low, middle sample ignored
    assign rx_start  = (rxd_d[4:3] == 2'b11) && (rxd_d[1:0] == 2'b00);
    assign half_done = (bit_cnt == HALF_LAST);
    assign bit_done  = (bit_cnt == BIT_LAST);

    // Timer restarts on every state advance
    always_comb
    begin
        case (state)
            RX_START:     cnt_restart = rx_start;
            RX_START_MID: cnt_restart = half_done;
            RX_DATA,
            RX_STOP:      cnt_restart = bit_done;
            default:      cnt_restart = 1'b0;
        endcase
    end

    // ==========================================================================
    // Receive FSM
    // ==========================================================================
    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            state        <= RX_IDLE;
            bit_idx      <= '0;
            o_uart_rts_n <= 1'b1;
        end
        else
        begin
            case (state)
                RX_IDLE:
                begin
                    // Hold off the sender while there is no room
                    if (i_fifo_full)
                        o_uart_rts_n <= 1'b1;
                    else
                    begin
                        o_uart_rts_n <= 1'b0;
                        state        <= RX_START;
                    end
                end
                RX_START:
                    if (rx_start)
                        state <= RX_START_MID;
                RX_START_MID:
                begin
                    if (half_done)
                    begin
                        bit_idx <= '0;
                        state   <= RX_DATA;
                    end
                end
                RX_DATA:
                begin
                    if (bit_done)
                    begin
                        bit_idx <= bit_idx + 3'd1;
                        if (bit_idx == 3'd7)
                            state <= RX_STOP;
                    end
                end
                // Mid stop bit, value not checked
                default:
                    if (bit_done)
                        state <= RX_IDLE;
            endcase
        end
    end

    // LSB arrives first, shifts down from the top
    always_ff @(posedge i_clk)
    begin
        if ((state == RX_DATA) && bit_done)
            o_fifo_data <= {rxd_d[0], o_fifo_data[7:1]};
    end

    assign o_fifo_push = (state == RX_STOP) && bit_done;

endmodule

/* logic/uart_tx.sv */
// UART transmitter
// Clear-to-send synchronizer and level report
// Free-running bit timer
// Transmit FSM, 8 data bits LSB first, two stop periods

`timescale 1ns/100ps

module uart_tx
#(
    parameter int CLKS_PER_BIT = 16
)
(
    input  logic                    i_clk,
    input  logic                    i_reset,
    input  logic                    i_uart_cts_n,
    input  logic                    i_fifo_empty,
    input  sync_uart_pkg::byte_t    i_fifo_data,
    output logic                    o_fifo_pop,
    output logic                    o_cts_active,
    output logic                    o_uart_txd
);
    import sync_uart_pkg::*;

    localparam int CNT_W = $clog2(CLKS_PER_BIT);
    localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(CLKS_PER_BIT - 1);

    logic [3:0]         cts_n_sync;
    logic [CNT_W-1:0]   bit_cnt;
    logic               bit_tick;
    logic               start_ok;
    logic [2:0]         bit_idx;
    tx_state_e          state;

    // ==========================================================================
    // Clear-to-send synchronizer and bit timer
    // ==========================================================================
    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            cts_n_sync <= 4'hf;
            bit_cnt    <= '0;
        end
        else
        begin
            cts_n_sync <= {cts_n_sync[2:0], i_uart_cts_n};
            bit_cnt    <= bit_tick ? '0 : bit_cnt + 1'b1;
        end
    end

    assign bit_tick     = (bit_cnt == BIT_LAST);
    // Oldest sample feeds the flag register
    assign o_cts_active = ~cts_n_sync[3];
    // Three settled samples low and something queued
    assign start_ok     = (cts_n_sync[3:1] == 3'b000) && !i_fifo_empty;

    // ==========================================================================
    // Transmit FSM, advances only on bit ticks
    // ==========================================================================
    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            state      <= TX_IDLE;
            bit_idx    <= '0;
            o_uart_txd <= 1'b1;
        end
        else if (bit_tick)
        begin
            case (state)
                TX_IDLE:
                begin
                    // Start bit goes out on this tick
                    if (start_ok)
                    begin
                        o_uart_txd <= 1'b0;
                        state      <= TX_START;
                    end
                end
                TX_START:
                begin
                    o_uart_txd <= i_fifo_data[0];
                    bit_idx    <= '0;
                    state      <= TX_DATA;
                end
                TX_DATA:
                begin
                    if (bit_idx == 3'd7)
                    begin
                        o_uart_txd <= 1'b1;
                        state      <= TX_STOP1;
                    end
                    else
                    begin
                        o_uart_txd <= i_fifo_data[bit_idx + 3'd1];
                        bit_idx    <= bit_idx + 3'd1;
                    end
                end
                TX_STOP1:
                    state <= TX_STOP2;
                default:
                begin
                    o_uart_txd <= 1'b1;
                    state      <= TX_IDLE;
                end
            endcase
        end
    end

    // Head byte leaves the FIFO at the end of the frame
    assign o_fifo_pop = bit_tick && (state == TX_STOP2);

endmodule

/* logic/byte_fifo.sv */
// Byte FIFO built from flip-flops
// Wrap-bit read and write pointers
// Head entry always visible on the output
// Occupancy count, full and empty derived from the pointers

`timescale 1ns/100ps

module byte_fifo
#(
    parameter int DEPTH = 16
)
(
    input  logic                    i_clk,
    input  logic                    i_reset,
    input  logic                    i_push,
    input  sync_uart_pkg::byte_t    i_data,
    input  logic                    i_pop,
    output sync_uart_pkg::byte_t    o_data,
    output logic [$clog2(DEPTH):0]  o_count,
    output logic                    o_full,
    output logic                    o_empty
);
    import sync_uart_pkg::*;

    localparam int AW = $clog2(DEPTH);

    // Payload storage
    byte_t          mem [DEPTH];
    // Extra MSB tells full from empty
    logic [AW:0]    wr_ptr;
    logic [AW:0]    rd_ptr;
    logic           push_ok;
    logic           pop_ok;

    // Drop pushes when full, ignore pops when empty
    assign push_ok = i_push && !o_full;
    assign pop_ok  = i_pop && !o_empty;

    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end
        else
        begin
            if (push_ok)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop_ok)
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (push_ok)
            mem[wr_ptr[AW-1:0]] <= i_data;
    end

    // Show-ahead head entry
    assign o_data  = mem[rd_ptr[AW-1:0]];

    // Flags follow pointer updates by one cycle
    assign o_count = wr_ptr - rd_ptr;
    assign o_empty = (wr_ptr == rd_ptr);
    assign o_full  = (wr_ptr == {~rd_ptr[AW], rd_ptr[AW-1:0]});

endmodule

/* logic/sync_uart_pkg.sv */
// Shared definitions for the system-clock UART
// Bus and serial data types
// Register offsets, control bit positions, unmapped read value
// Transmit and receive FSM state encodings

package sync_uart_pkg;

    // One serial data byte
    typedef logic [7:0]  byte_t;

    // Bus data and address words
    typedef logic [31:0] wb_data_t;
    typedef logic [31:0] wb_addr_t;

    // Register offsets, low 16 address bits only
    typedef enum logic [15:0] {
        UART_DR  = 16'h0000,
        UART_FR  = 16'h0018,
        UART_CR  = 16'h0030,
        UART_IIR = 16'h0034
    } uart_reg_e;

    // Control register bits
    localparam int CR_TX_INT_EN = 5;
    localparam int CR_RX_INT_EN = 4;

    // Returned for any unmapped offset
    localparam wb_data_t READ_DEFAULT = 32'h00c0ffee;

    // Transmit FSM, data bits share one state
    typedef enum logic [2:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP1,
        TX_STOP2
    } tx_state_e;

    // Receive FSM
    typedef enum logic [2:0] {
        RX_IDLE,
        RX_START,
        RX_START_MID,
        RX_DATA,
        RX_STOP
    } rx_state_e;

endpackage
